// File: source/mem_params.svh
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Queue depths
`define MEM_LQ_DEPTH 4
`define MEM_SQ_DEPTH 4

// Word-addressed data memory
`define MEM_ADDR_W   6
`define MEM_WORDS    64
`define MEM_DATA_W   32

// Core-side tag widths
`define MEM_ROB_W    5
`define MEM_PREG_W   6

`endif

// File: source/mem_pkg.sv
`include "mem_params.svh"

package mem_pkg;

    typedef logic [`MEM_ROB_W-1:0]  t_rob_id;
    typedef logic [`MEM_PREG_W-1:0] t_preg;
    typedef logic [`MEM_ADDR_W-1:0] t_addr;
    typedef logic [`MEM_DATA_W-1:0] t_word;

    // Dispatch packet carries no address yet
    typedef struct packed {
        logic    is_store;
        t_rob_id rob_id;
        t_preg   dest_preg;
    } t_disp_pkt;

    typedef struct packed {
        t_rob_id rob_id;
        t_addr   addr;
        t_word   store_data;  // Ignored for loads
    } t_iss_pkt;

    // Queue to pipeline, through the arbiter
    typedef struct packed {
        logic    is_store;
        t_rob_id rob_id;
        t_preg   dest_preg;
        t_addr   addr;
        t_word   store_data;
    } t_pipe_req;

    typedef struct packed {
        t_rob_id rob_id;
    } t_complete_pkt;

    typedef struct packed {
        t_preg preg;
        t_word data;
    } t_prf_wr_pkt;

    typedef struct packed {
        logic valid;
    } t_nuke_pkt;

endpackage

// File: source/load_queue.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module load_queue (
    input  logic               clk,
    input  logic               arst_n,
    input  mem_pkg::t_nuke_pkt nuke_pkt,
    input  logic               disp_valid,
    input  mem_pkg::t_disp_pkt disp_pkt,
    input  logic               iss_valid,
    input  mem_pkg::t_iss_pkt  iss_pkt,
    output logic               lq_ready,
    output logic               req,
    output mem_pkg::t_pipe_req req_pkt,
    input  logic               gnt
);
    import mem_pkg::*;

    localparam int DEPTH = `MEM_LQ_DEPTH;
    localparam int AGE_W = $clog2(DEPTH);

    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_ready;   // Address known
    logic [AGE_W-1:0] ent_age [DEPTH];  // Count of older live entries
    t_rob_id          ent_rob [DEPTH];
    t_preg            ent_preg [DEPTH];
    t_addr            ent_addr [DEPTH];

    logic [DEPTH-1:0] iss_hit;
    logic             alloc;
    logic             alloc_found;
    logic [AGE_W-1:0] alloc_idx;
    logic [AGE_W:0]   n_valid;
    logic             sel_found;
    logic [AGE_W-1:0] sel_idx;
    logic [AGE_W-1:0] sel_age;
    logic             held;        // Request pending from last cycle
    logic [AGE_W-1:0] held_idx;
    logic             take;

    // First free slot and occupancy
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        n_valid     = '0;
        for (int i = 0; i < DEPTH; i++) begin
            n_valid = n_valid + (AGE_W+1)'(ent_valid[i]);
            if (!ent_valid[i] && !alloc_found) begin
                alloc_found = 1'b1;
                alloc_idx   = AGE_W'(i);
            end
        end
    end

    // Oldest ready entry, unless a request is already on the wire
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_age   = '1;
        for (int i = 0; i < DEPTH; i++) begin
            if (ent_valid[i] && ent_ready[i] && (!sel_found || ent_age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = AGE_W'(i);
                sel_age   = ent_age[i];
            end
        end
        if (held) begin
            sel_found = 1'b1;
            sel_idx   = held_idx;
        end
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            iss_hit[i] = iss_valid && ent_valid[i] && !ent_ready[i]
                         && ent_rob[i] == iss_pkt.rob_id;
        end
    end

    assign lq_ready = alloc_found;
    assign alloc    = disp_valid && !disp_pkt.is_store && alloc_found;
    assign req      = sel_found && !nuke_pkt.valid;  // No new grants while flushing
    assign take     = req && gnt;

    assign req_pkt.is_store   = 1'b0;
    assign req_pkt.rob_id     = ent_rob[sel_idx];
    assign req_pkt.dest_preg  = ent_preg[sel_idx];
    assign req_pkt.addr       = ent_addr[sel_idx];
    assign req_pkt.store_data = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
            ent_ready <= '0;
            held      <= 1'b0;
            for (int i = 0; i < DEPTH; i++) ent_age[i] <= '0;
        end else if (nuke_pkt.valid) begin
            ent_valid <= '0;
            ent_ready <= '0;
            held      <= 1'b0;
        end else begin
            held <= req && !gnt;
            for (int i = 0; i < DEPTH; i++) begin
                if (take && sel_idx == AGE_W'(i)) begin
                    ent_valid[i] <= 1'b0;
                    ent_ready[i] <= 1'b0;
                end else begin
                    if (iss_hit[i]) ent_ready[i] <= 1'b1;
                    if (take && ent_valid[i] && ent_age[i] > ent_age[sel_idx]) begin
                        ent_age[i] <= ent_age[i] - 1'b1;  // Freed entry was older
                    end
                end
            end
            if (alloc) begin
                ent_valid[alloc_idx] <= 1'b1;
                ent_ready[alloc_idx] <= 1'b0;
                ent_age[alloc_idx]   <= AGE_W'(n_valid - (AGE_W+1)'(take));
            end
        end
    end

    always_ff @(posedge clk) begin
        held_idx <= sel_idx;
        if (alloc) begin
            ent_rob[alloc_idx]  <= disp_pkt.rob_id;
            ent_preg[alloc_idx] <= disp_pkt.dest_preg;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (iss_hit[i]) ent_addr[i] <= iss_pkt.addr;
        end
    end

endmodule

// File: source/store_queue.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module store_queue (
    input  logic               clk,
    input  logic               arst_n,
    input  mem_pkg::t_nuke_pkt nuke_pkt,
    input  logic               disp_valid,
    input  mem_pkg::t_disp_pkt disp_pkt,
    input  logic               iss_valid,
    input  mem_pkg::t_iss_pkt  iss_pkt,
    output logic               sq_ready,
    output logic               req,
    output mem_pkg::t_pipe_req req_pkt,
    input  logic               gnt
);
    import mem_pkg::*;

    localparam int DEPTH = `MEM_SQ_DEPTH;
    localparam int AGE_W = $clog2(DEPTH);

    logic [DEPTH-1:0] ent_valid;
    logic [DEPTH-1:0] ent_ready;
    logic [AGE_W-1:0] ent_age [DEPTH];
    t_rob_id          ent_rob [DEPTH];
    t_addr            ent_addr [DEPTH];
    t_word            ent_data [DEPTH];

    logic [DEPTH-1:0] iss_hit;
    logic             alloc;
    logic             alloc_found;
    logic [AGE_W-1:0] alloc_idx;
    logic [AGE_W:0]   n_valid;
    logic             sel_found;
    logic [AGE_W-1:0] sel_idx;
    logic [AGE_W-1:0] sel_age;
    logic             take;

    // Free slot search, oldest ready pick and issue match in one pass
    always_comb begin
        alloc_found = 1'b0;
        alloc_idx   = '0;
        n_valid     = '0;
        sel_found   = 1'b0;
        sel_idx     = '0;
        sel_age     = '1;
        for (int i = 0; i < DEPTH; i++) begin
            n_valid = n_valid + (AGE_W+1)'(ent_valid[i]);
            if (!ent_valid[i] && !alloc_found) begin
                alloc_found = 1'b1;
                alloc_idx   = AGE_W'(i);
            end
            if (ent_valid[i] && ent_ready[i] && (!sel_found || ent_age[i] < sel_age)) begin
                sel_found = 1'b1;
                sel_idx   = AGE_W'(i);
                sel_age   = ent_age[i];
            end
            iss_hit[i] = iss_valid && ent_valid[i] && !ent_ready[i]
                         && ent_rob[i] == iss_pkt.rob_id;
        end
    end

    // Highest priority at the arbiter, so a request never waits
    assign sq_ready = alloc_found;
    assign alloc    = disp_valid && disp_pkt.is_store && alloc_found;
    assign req      = sel_found && !nuke_pkt.valid;
    assign take     = req && gnt;

    assign req_pkt.is_store   = 1'b1;
    assign req_pkt.rob_id     = ent_rob[sel_idx];
    assign req_pkt.dest_preg  = '0;
    assign req_pkt.addr       = ent_addr[sel_idx];
    assign req_pkt.store_data = ent_data[sel_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
            ent_ready <= '0;
            for (int i = 0; i < DEPTH; i++) ent_age[i] <= '0;
        end else if (nuke_pkt.valid) begin
            ent_valid <= '0;
            ent_ready <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (take && sel_idx == AGE_W'(i)) begin
                    ent_valid[i] <= 1'b0;
                    ent_ready[i] <= 1'b0;
                end else begin
                    if (iss_hit[i]) ent_ready[i] <= 1'b1;
                    if (take && ent_valid[i] && ent_age[i] > sel_age) begin
                        ent_age[i] <= ent_age[i] - 1'b1;
                    end
                end
            end
            if (alloc) begin
                ent_valid[alloc_idx] <= 1'b1;
                ent_ready[alloc_idx] <= 1'b0;
                ent_age[alloc_idx]   <= AGE_W'(n_valid - (AGE_W+1)'(take));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) ent_rob[alloc_idx] <= disp_pkt.rob_id;
        for (int i = 0; i < DEPTH; i++) begin
            if (iss_hit[i]) begin
                ent_addr[i] <= iss_pkt.addr;
                ent_data[i] <= iss_pkt.store_data;
            end
        end
    end

endmodule

// File: source/mempipe_arb.sv
`timescale 1ns/1ps

module mempipe_arb (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               st_req,
    input  mem_pkg::t_pipe_req st_req_pkt,
    output logic               st_gnt,
    input  logic               ld_req,
    input  mem_pkg::t_pipe_req ld_req_pkt,
    output logic               ld_gnt,
    output logic               pipe_valid,
    output mem_pkg::t_pipe_req pipe_req
);
    import mem_pkg::*;

    // Stores always win
    assign st_gnt = st_req;
    assign ld_gnt = ld_req && !st_req;

    // Grant cycle is mm0, register into mm1
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid <= 1'b0;
        end else begin
            pipe_valid <= st_gnt || ld_gnt;
        end
    end

    always_ff @(posedge clk) begin
        pipe_req <= st_gnt ? st_req_pkt : ld_req_pkt;
    end

endmodule

// File: source/mempipe.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mempipe (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mem_pkg::t_nuke_pkt     nuke_pkt,
    input  logic                   pipe_valid,
    input  mem_pkg::t_pipe_req     pipe_req,
    output logic                   complete_valid,
    output mem_pkg::t_complete_pkt complete_pkt,
    output logic                   prf_wr_en,
    output mem_pkg::t_prf_wr_pkt   prf_wr_pkt
);
    import mem_pkg::*;

    t_word   mem_arr [`MEM_WORDS];

    t_word   rd_data_mm1;
    logic    st_wr_mm1;

    logic    valid_mm2;
    logic    is_store_mm2;
    t_rob_id rob_mm2;
    t_preg   preg_mm2;
    t_word   data_mm2;

    logic    valid_mm3;
    logic    is_store_mm3;
    t_rob_id rob_mm3;
    t_preg   preg_mm3;
    t_word   data_mm3;

    // mm1 array access
    // Store write lands at the end of mm1, so a load one cycle behind sees it
    assign st_wr_mm1   = pipe_valid && pipe_req.is_store && !nuke_pkt.valid;
    assign rd_data_mm1 = mem_arr[pipe_req.addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MEM_WORDS; i++) mem_arr[i] <= '0;
        end else if (st_wr_mm1) begin
            mem_arr[pipe_req.addr] <= pipe_req.store_data;
        end
    end

    // Stage valids cleared by nuke
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_mm2 <= 1'b0;
            valid_mm3 <= 1'b0;
        end else if (nuke_pkt.valid) begin
            valid_mm2 <= 1'b0;
            valid_mm3 <= 1'b0;
        end else begin
            valid_mm2 <= pipe_valid;
            valid_mm3 <= valid_mm2;
        end
    end

    // mm2 and mm3 payload
    always_ff @(posedge clk) begin
        is_store_mm2 <= pipe_req.is_store;
        rob_mm2      <= pipe_req.rob_id;
        preg_mm2     <= pipe_req.dest_preg;
        data_mm2     <= rd_data_mm1;  // Read data registered here

        is_store_mm3 <= is_store_mm2;
        rob_mm3      <= rob_mm2;
        preg_mm3     <= preg_mm2;
        data_mm3     <= data_mm2;
    end

    // mm3 reports to ROB and PRF
    assign complete_valid      = valid_mm3;
    assign complete_pkt.rob_id = rob_mm3;
    assign prf_wr_en           = valid_mm3 && !is_store_mm3;  // Loads only
    assign prf_wr_pkt.preg     = preg_mm3;
    assign prf_wr_pkt.data     = data_mm3;

endmodule

// File: source/mem_unit.sv
`timescale 1ns/1ps

module mem_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  mem_pkg::t_nuke_pkt     nuke_pkt,
    input  logic                   disp_valid,
    input  mem_pkg::t_disp_pkt     disp_pkt,
    input  logic                   iss_valid,
    input  mem_pkg::t_iss_pkt      iss_pkt,
    output logic                   lq_ready,
    output logic                   sq_ready,
    output logic                   complete_valid,
    output mem_pkg::t_complete_pkt complete_pkt,
    output logic                   prf_wr_en,
    output mem_pkg::t_prf_wr_pkt   prf_wr_pkt
);
    import mem_pkg::*;

    logic      ld_req;
    t_pipe_req ld_req_pkt;
    logic      ld_gnt;
    logic      st_req;
    t_pipe_req st_req_pkt;
    logic      st_gnt;
    logic      pipe_valid;   // mm1
    t_pipe_req pipe_req;

    load_queue u_load_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .nuke_pkt   (nuke_pkt),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .iss_valid  (iss_valid),
        .iss_pkt    (iss_pkt),
        .lq_ready   (lq_ready),
        .req        (ld_req),
        .req_pkt    (ld_req_pkt),
        .gnt        (ld_gnt)
    );

    store_queue u_store_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .nuke_pkt   (nuke_pkt),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .iss_valid  (iss_valid),
        .iss_pkt    (iss_pkt),
        .sq_ready   (sq_ready),
        .req        (st_req),
        .req_pkt    (st_req_pkt),
        .gnt        (st_gnt)
    );

    mempipe_arb u_mempipe_arb (
        .clk        (clk),
        .arst_n     (arst_n),
        .st_req     (st_req),
        .st_req_pkt (st_req_pkt),
        .st_gnt     (st_gnt),
        .ld_req     (ld_req),
        .ld_req_pkt (ld_req_pkt),
        .ld_gnt     (ld_gnt),
        .pipe_valid (pipe_valid),
        .pipe_req   (pipe_req)
    );

    mempipe u_mempipe (
        .clk            (clk),
        .arst_n         (arst_n),
        .nuke_pkt       (nuke_pkt),
        .pipe_valid     (pipe_valid),
        .pipe_req       (pipe_req),
        .complete_valid (complete_valid),
        .complete_pkt   (complete_pkt),
        .prf_wr_en      (prf_wr_en),
        .prf_wr_pkt     (prf_wr_pkt)
    );

endmodule

// File: bench/mem_unit_tests.svh
`ifndef MEM_UNIT_TESTS_SVH
`define MEM_UNIT_TESTS_SVH

task automatic begin_test(string name);
    cur_test       = name;
    test_err_start = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors == test_err_start) begin
        $display("test %s: ok", cur_test);
    end else begin
        tests_failed++;
        $display("test %s: %0d errors", cur_test, errors - test_err_start);
    end
endtask

function automatic t_rob_id new_rob();
    next_rob = next_rob + 1'b1;
    return next_rob;
endfunction

function automatic t_addr rand_addr();
    return t_addr'(next_rand() >> 20);  // Upper LCG bits are the better ones
endfunction

// Opens a cycle with all request inputs idle
task automatic next_cycle();
    @(posedge clk);
    #1;
    disp_valid = 1'b0;
    iss_valid  = 1'b0;
    nuke_pkt   = '0;
endtask

task automatic idle(int n);
    repeat (n) next_cycle();
endtask

task automatic dispatch(logic st, t_rob_id rob, t_preg preg);
    next_cycle();
    if (st) check_flag("sq_ready before dispatch", 1'b1, sq_ready);
    else check_flag("lq_ready before dispatch", 1'b1, lq_ready);
    disp_valid         = 1'b1;
    disp_pkt.is_store  = st;
    disp_pkt.rob_id    = rob;
    disp_pkt.dest_preg = preg;
endtask

task automatic issue(t_rob_id rob, t_addr addr, t_word data);
    next_cycle();
    iss_valid          = 1'b1;
    iss_pkt.rob_id     = rob;
    iss_pkt.addr       = addr;
    iss_pkt.store_data = data;
endtask

task automatic expect_store(t_rob_id rob, t_addr addr, t_word data);
    t_exp_op op;
    op.is_load = 1'b0;
    op.rob     = rob;
    op.prf     = '0;
    ref_mem[addr] = data;
    exp_q.push_back(op);
endtask

task automatic expect_load(t_rob_id rob, t_preg preg, t_addr addr);
    t_exp_op op;
    op.is_load  = 1'b1;
    op.rob      = rob;
    op.prf.preg = preg;
    op.prf.data = ref_mem[addr];
    exp_q.push_back(op);
endtask

// Waits until every expected completion has been seen
task automatic wait_drain();
    int n;
    n = 0;
    next_cycle();
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
        @(posedge clk);
        n++;
    end
    #1;
    if (exp_q.size() != 0) begin
        $display("%s: timed out with %0d completions missing", cur_test, exp_q.size());
        errors++;
        exp_q.delete();
    end
endtask

task automatic run_store_load();
    t_rob_id st_rob;
    t_rob_id ld_rob;
    t_addr   addr;
    t_word   data;
    t_preg   preg;
    addr   = rand_addr();
    data   = next_rand();
    preg   = t_preg'(next_rand() >> 16);
    st_rob = new_rob();
    dispatch(1'b1, st_rob, '0);
    issue(st_rob, addr, data);
    expect_store(st_rob, addr, data);
    wait_drain();
    ld_rob = new_rob();
    dispatch(1'b0, ld_rob, preg);
    issue(ld_rob, addr, '0);
    expect_load(ld_rob, preg, addr);  // Carries the stored word
    wait_drain();
endtask

task automatic reset_state();
    begin_test("reset_state");
    check_flag("lq_ready", 1'b1, lq_ready);
    check_flag("sq_ready", 1'b1, sq_ready);
    check_flag("complete_valid", 1'b0, complete_valid);
    check_flag("prf_wr_en", 1'b0, prf_wr_en);
    end_test();
endtask

task automatic store_then_load();
    begin_test("store_then_load");
    run_store_load();
    end_test();
endtask

task automatic completion_timing();
    t_rob_id     rob;
    t_addr       addr;
    t_preg       preg;
    int unsigned issue_cyc;
    begin_test("completion_timing");
    rob  = new_rob();
    addr = rand_addr();
    preg = t_preg'(next_rand() >> 16);
    dispatch(1'b0, rob, preg);
    issue(rob, addr, '0);
    issue_cyc = cyc;
    expect_load(rob, preg, addr);
    wait_drain();
    check_delay("issue to completion", 4, int'(last_comp_cyc - issue_cyc));
    check_delay("grant to completion", 3, int'(last_comp_cyc - last_gnt_cyc));
    end_test();
endtask

task automatic reverse_issue_order();
    t_rob_id robs [4];
    t_preg   pregs [4];
    t_addr   base;
    t_rob_id st_rob;
    t_word   data;
    begin_test("reverse_issue_order");
    base = rand_addr();
    // Fresh data at four neighbouring words first
    for (int i = 0; i < 4; i++) begin
        st_rob = new_rob();
        data   = next_rand();
        dispatch(1'b1, st_rob, '0);
        issue(st_rob, base + t_addr'(i), data);
        expect_store(st_rob, base + t_addr'(i), data);
    end
    wait_drain();
    for (int i = 0; i < 4; i++) begin
        robs[i]  = new_rob();
        pregs[i] = t_preg'(next_rand() >> 16);
        dispatch(1'b0, robs[i], pregs[i]);
    end
    for (int i = 3; i >= 0; i--) begin
        issue(robs[i], base + t_addr'(i), '0);
        expect_load(robs[i], pregs[i], base + t_addr'(i));
    end
    wait_drain();
    end_test();
endtask

task automatic store_priority();
    t_rob_id rob;
    t_addr   addr;
    t_word   data;
    t_preg   preg;
    begin_test("store_priority");
    // One issue port, so a shared rob id readies both queues in one cycle
    rob  = new_rob();
    addr = rand_addr();
    data = next_rand();
    preg = t_preg'(next_rand() >> 16);
    dispatch(1'b1, rob, '0);
    dispatch(1'b0, rob, preg);
    issue(rob, addr, data);
    expect_store(rob, addr, data);
    expect_load(rob, preg, addr);
    wait_drain();
    check_delay("store to load completion", 1, int'(last_comp_cyc - prev_comp_cyc));
    end_test();
endtask

task automatic full_load_queue();
    t_rob_id robs [4];
    t_preg   pregs [4];
    t_addr   addrs [4];
    begin_test("full_load_queue");
    for (int i = 0; i < 4; i++) begin
        robs[i]  = new_rob();
        pregs[i] = t_preg'(next_rand() >> 16);
        addrs[i] = rand_addr();
        dispatch(1'b0, robs[i], pregs[i]);
    end
    next_cycle();
    check_flag("lq_ready with four loads waiting", 1'b0, lq_ready);
    check_flag("sq_ready with four loads waiting", 1'b1, sq_ready);
    issue(robs[0], addrs[0], '0);
    expect_load(robs[0], pregs[0], addrs[0]);
    wait_drain();
    check_flag("lq_ready after one load completed", 1'b1, lq_ready);
    for (int i = 1; i < 4; i++) begin
        issue(robs[i], addrs[i], '0);
        expect_load(robs[i], pregs[i], addrs[i]);
    end
    wait_drain();
    end_test();
endtask

task automatic nuke_flush();
    t_rob_id ld_robs [5];
    t_rob_id st_robs [4];
    begin_test("nuke_flush");
    for (int i = 0; i < 4; i++) begin
        ld_robs[i] = new_rob();
        st_robs[i] = new_rob();
        dispatch(1'b0, ld_robs[i], t_preg'(next_rand() >> 16));
        dispatch(1'b1, st_robs[i], '0);  // Never issued, memory stays as is
    end
    ld_robs[4] = new_rob();
    issue(ld_robs[0], rand_addr(), '0);
    next_cycle();           // Grant frees one load slot
    dispatch(1'b0, ld_robs[4], t_preg'(next_rand() >> 16));
    next_cycle();
    check_flag("lq_ready before nuke", 1'b0, lq_ready);
    check_flag("sq_ready before nuke", 1'b0, sq_ready);
    nuke_pkt.valid = 1'b1;  // First load in mm2, both queues full
    idle(8);                // Monitor flags any completion here
    check_flag("lq_ready after nuke", 1'b1, lq_ready);
    check_flag("sq_ready after nuke", 1'b1, sq_ready);
    run_store_load();
    end_test();
endtask

`endif

// File: bench/mem_unit_tb.sv
`timescale 1ns/1ps
`include "mem_params.svh"

module mem_unit_tb;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_LIMIT  = 20;   // Cycles one wait for completions may take
    localparam int NUM_TESTS    = 7;
    localparam int TEST_CYCLES  = 60;   // Upper bound for the longest test
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 100) * CLK_PERIOD;

    // One expected completion in grant order
    typedef struct packed {
        logic        is_load;
        t_rob_id     rob;
        t_prf_wr_pkt prf;
    } t_exp_op;

    logic          clk;
    logic          arst_n;
    t_nuke_pkt     nuke_pkt;
    logic          disp_valid;
    t_disp_pkt     disp_pkt;
    logic          iss_valid;
    t_iss_pkt      iss_pkt;
    logic          lq_ready;
    logic          sq_ready;
    logic          complete_valid;
    t_complete_pkt complete_pkt;
    logic          prf_wr_en;
    t_prf_wr_pkt   prf_wr_pkt;

    t_word         ref_mem [`MEM_WORDS];  // Model of the data memory
    t_exp_op       exp_q [$];
    logic [31:0]   lcg_state;
    t_rob_id       next_rob;
    int unsigned   cyc = 0;
    int unsigned   last_comp_cyc;
    int unsigned   prev_comp_cyc;
    int unsigned   last_gnt_cyc;
    string         cur_test;
    int            errors;
    int            tests_run;
    int            tests_failed;
    int            test_err_start;

    mem_unit u_mem_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .nuke_pkt       (nuke_pkt),
        .disp_valid     (disp_valid),
        .disp_pkt       (disp_pkt),
        .iss_valid      (iss_valid),
        .iss_pkt        (iss_pkt),
        .lq_ready       (lq_ready),
        .sq_ready       (sq_ready),
        .complete_valid (complete_valid),
        .complete_pkt   (complete_pkt),
        .prf_wr_en      (prf_wr_en),
        .prf_wr_pkt     (prf_wr_pkt)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_complete(t_rob_id exp_rob, t_rob_id act_rob);
        if (act_rob !== exp_rob) begin
            $display("[FAIL] %s: rob_id expected %0d, actual %0d", cur_test, exp_rob, act_rob);
            errors++;
        end
    endtask

    task automatic check_prf_wr(t_prf_wr_pkt exp_wr, t_prf_wr_pkt act_wr);
        if (act_wr !== exp_wr) begin
            $display("[FAIL] %s: prf write expected preg %0d data %h, actual preg %0d data %h",
                     cur_test, exp_wr.preg, exp_wr.data, act_wr.preg, act_wr.data);
            errors++;
        end
    endtask

    task automatic check_flag(string what, logic exp_val, logic act_val);
        if (act_val !== exp_val) begin
            $display("[FAIL] %s: %s expected %b, actual %b", cur_test, what, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_delay(string what, int exp_cycles, int act_cycles);
        if (act_cycles != exp_cycles) begin
            $display("[FAIL] %s: %s expected %0d cycles, actual %0d",
                     cur_test, what, exp_cycles, act_cycles);
            errors++;
        end
    endtask

    // Completion monitor sampling at the falling edge
    always @(negedge clk) begin : monitor
        t_exp_op head;
        if (arst_n) begin
            if (u_mem_unit.st_gnt || u_mem_unit.ld_gnt) last_gnt_cyc = cyc;
            if (complete_valid) begin
                prev_comp_cyc = last_comp_cyc;
                last_comp_cyc = cyc;
                if (exp_q.size() == 0) begin
                    $display("%s: rob_id %0d completed although nothing was outstanding",
                             cur_test, complete_pkt.rob_id);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    check_complete(head.rob, complete_pkt.rob_id);
                    if (head.is_load && !prf_wr_en) begin
                        $display("%s: load rob_id %0d completed without a register write",
                                 cur_test, head.rob);
                        errors++;
                    end else if (!head.is_load && prf_wr_en) begin
                        $display("%s: store rob_id %0d wrote a register", cur_test, head.rob);
                        errors++;
                    end else if (head.is_load) begin
                        check_prf_wr(head.prf, prf_wr_pkt);
                    end
                end
            end else if (prf_wr_en) begin
                $display("%s: register write seen without a completion", cur_test);
                errors++;
            end
        end
    end

    `include "mem_unit_tests.svh"

    initial begin
        arst_n     = 1'b0;
        nuke_pkt   = '0;
        disp_valid = 1'b0;
        disp_pkt   = '0;
        iss_valid  = 1'b0;
        iss_pkt    = '0;
        lcg_state  = 32'h66ad;
        next_rob   = '0;
        errors     = 0;
        tests_run  = 0;
        tests_failed  = 0;
        last_comp_cyc = 0;
        prev_comp_cyc = 0;
        last_gnt_cyc  = 0;
        cur_test   = "reset";
        for (int i = 0; i < `MEM_WORDS; i++) ref_mem[i] = '0;  // Memory clears at reset
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        reset_state();
        store_then_load();
        completion_timing();
        reverse_issue_order();
        store_priority();
        full_load_queue();
        nuke_flush();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

// File: mem_unit.f
+incdir+source
+incdir+bench
source/mem_pkg.sv
source/load_queue.sv
source/store_queue.sv
source/mempipe_arb.sv
source/mempipe.sv
source/mem_unit.sv
bench/mem_unit_tb.sv
